//--- verif/pulse_cases.txt
# w elem sel addr count i q step_i step_q : ramp fill, sel 0 envelope, sel 1 carrier
# c elem offset env_start env_len car_start rnd amp_i amp_q : rnd 1 draws amp; e count
# single pulse on element 0
w 0 0 000 8 1000 0000 0800 0100
w 0 1 000 8 7fff 0000 f000 1000
c 0 0 000 8 000 0 4000 0000
e 8
# all four elements in the same cycle, different lengths
w 1 0 010 c 2000 1000 0400 fc00
w 1 1 010 c 4000 c000 0800 0800
w 2 0 000 6 7000 7000 0000 0000
w 2 1 000 6 7fff 7fff 0000 0000
w 3 0 020 a 8001 0100 1000 0010
w 3 1 020 a 4000 0000 0000 0400
c 0 0 000 8 000 0 4000 0000
c 1 0 010 c 010 0 7fff 0000
c 2 0 000 6 000 0 7fff 7fff
c 3 0 020 a 020 0 c000 2000
e c
# two queued pulses on element 1 run back to back
c 1 0 010 5 010 0 3000 1000
c 1 1 014 7 012 0 d000 0400
e c
# empty pulse returns its credit only
c 2 0 000 0 000 0 7fff 0000
e 0
# full queue with an empty pulse between two real ones
c 3 0 020 4 020 0 4000 4000
c 3 1 000 0 000 0 4000 4000
c 3 3 024 6 024 0 4000 c000
e a
# random amplitudes on every element
c 0 0 000 8 000 1 0 0
c 3 0 020 a 020 1 0 0
c 2 1 000 6 000 1 0 0
c 1 2 010 c 010 1 0 0
c 0 4 000 8 000 1 0 0
e 10

//--- project.f
+incdir+verif
rtl/pulse_pkg.sv
rtl/sample_mem.sv
rtl/pulse_sequencer.sv
rtl/iq_modulator.sv
rtl/pulse_element.sv
rtl/element_sum.sv
rtl/pulse_gen_top.sv
verif/pulse_gen_tb.sv

//--- Bender.yml
package:
  name: pulse_gen

sources:
  - files:
      - rtl/pulse_pkg.sv
      - rtl/sample_mem.sv
      - rtl/pulse_sequencer.sv
      - rtl/iq_modulator.sv
      - rtl/pulse_element.sv
      - rtl/element_sum.sv
      - rtl/pulse_gen_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/pulse_gen_tb.sv

//--- verif/pulse_gen_checks.svh
// pulse generator reference model
`ifndef PULSE_GEN_CHECKS_SVH
`define PULSE_GEN_CHECKS_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// complex product shifted right by 15 and cut to 16 bits
function automatic pulse_pkg::iq_t cmul_scale(input pulse_pkg::iq_t a, input pulse_pkg::iq_t b);
	longint re;
	longint im;
	pulse_pkg::iq_t r;
	re = longint'($signed(a.i)) * longint'($signed(b.i))
		- longint'($signed(a.q)) * longint'($signed(b.q));
	im = longint'($signed(a.i)) * longint'($signed(b.q))
		+ longint'($signed(a.q)) * longint'($signed(b.i));
	re = re >>> 15;
	im = im >>> 15;
	r.i = re[15:0];
	r.q = im[15:0];
	return r;
endfunction

task automatic load_mem(input int e, input int sel, input int addr, input int n,
		input logic [15:0] i0, input logic [15:0] q0, input logic [15:0] di,
		input logic [15:0] dq);
	pulse_pkg::mem_wr_t w;
	limit += n + 1;
	for (int k = 0; k < n; k++) begin
		w.en = 1'b1;
		w.elem = 8'(e);
		w.sel = pulse_pkg::mem_sel_t'(sel[0]);
		w.addr = pulse_pkg::ADDR_W'(addr + k);
		w.data.i = i0 + 16'(k) * di;  // ramp that wraps at 16 bits
		w.data.q = q0 + 16'(k) * dq;
		@(posedge elem);
		mem_wr <= w;
		if (sel[0]) begin
			car_model[e][w.addr] = w.data;
		end else begin
			env_model[e][w.addr] = w.data;
		end
	end
	@(posedge elem);
	mem_wr <= '0;
endtask

// expected summed stream per case cycle with idle elements adding zero
task automatic build_expected(output int len, output int nvalid);
	int free_at [NELEM];
	int e;
	int p;
	int t;
	int n_len;
	pulse_pkg::iq_t s;
	logic [pulse_pkg::ADDR_W-1:0] ea;
	logic [pulse_pkg::ADDR_W-1:0] ca;
	for (t = 0; t < MAX_CYC; t++) begin
		exp_valid[t] = 1'b0;
		exp_sum[t] = '0;
	end
	for (e = 0; e < NELEM; e++) begin
		free_at[e] = 0;
	end
	len = 0;
	for (int n = 0; n < ncmd; n++) begin
		e = cmd_elem[n];
		n_len = int'(cmd_list[n].env_len);
		p = cmd_off[n] + ISSUE_LAT;
		if (free_at[e] > p) begin
			p = free_at[e];  // queued behind the running pulse
		end
		if (p + OUT_LAT + n_len + 4 >= MAX_CYC) begin
			abort_run("case too long for the expected stream buffer");
		end
		for (int k = 0; k < n_len; k++) begin
			ea = cmd_list[n].env_start + pulse_pkg::ADDR_W'(k);
			ca = cmd_list[n].car_start + pulse_pkg::ADDR_W'(k);
			s = cmul_scale(cmul_scale(env_model[e][ea], car_model[e][ca]), cmd_list[n].amp);
			t = p + OUT_LAT + k;
			exp_sum[t].i = exp_sum[t].i + s.i;
			exp_sum[t].q = exp_sum[t].q + s.q;
			exp_valid[t] = 1'b1;
		end
		free_at[e] = p + ((n_len == 0) ? 1 : n_len);  // empty pulse still takes a pop
		if (p + OUT_LAT + n_len > len) begin
			len = p + OUT_LAT + n_len;
		end
	end
	nvalid = 0;
	for (t = 0; t < MAX_CYC; t++) begin
		if (exp_valid[t]) begin
			nvalid++;
		end
	end
endtask

task automatic drive_cycle(input int t);
	logic [NELEM-1:0] v;
	v = '0;
	for (int n = 0; n < ncmd; n++) begin
		if (cmd_off[n] == t) begin
			if (credits[cmd_elem[n]] == 0) begin
				abort_run("command due on an element with no credit left");
			end
			credits[cmd_elem[n]]--;
			v[cmd_elem[n]] = 1'b1;
			cmd[cmd_elem[n]] <= cmd_list[n];
		end
	end
	cmd_valid <= v;
endtask

task automatic run_case(input int want);
	int len;
	int nvalid;
	int t;
	build_expected(len, nvalid);
	if (nvalid != want) begin
		abort_run("case file sample count disagrees with the model");
	end
	limit += len + 50;
	t = 0;
	@(posedge elem);
	base = cyc + 1;  // index of this edge
	case_on = 1'b1;
	while (t <= len + 2) begin
		drive_cycle(t);
		@(posedge elem);
		t++;
	end
	cmd_valid <= '0;
	case_on = 1'b0;
	for (int e = 0; e < NELEM; e++) begin
		check_credit(e, credits[e], CMD_DEPTH);
	end
endtask

task automatic check_sample(input pulse_pkg::iq_t got, input pulse_pkg::iq_t exp);
	if (got !== exp) begin
		abort_run($sformatf("error out_sample got %h expected %h", got, exp));
	end
endtask

task automatic check_valid(input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("error out_valid got %h expected %h", got, exp));
	end
endtask

task automatic check_credit(input int e, input int got, input int exp);
	if (got != exp) begin
		abort_run($sformatf("error cmd_credit[%0d] credits got %h expected %h", e, got, exp));
	end
endtask

`endif

//--- verif/pulse_gen_tb.sv
// pulse generator testbench
`timescale 1ns/1ps

module pulse_gen_tb;

	localparam int NELEM = 4;
	localparam int CMD_DEPTH = 2;
	localparam int MAX_CMD = 16;
	localparam int MAX_CYC = 256;
	localparam int ISSUE_LAT = 2;  // cmd_valid edge to first address edge
	localparam int OUT_LAT = 1 + pulse_pkg::MOD_LAT + $clog2(NELEM) + 1;

	logic elem = 1'b0;
	logic rst_n;
	logic [NELEM-1:0] cmd_valid;
	pulse_pkg::pulse_cmd_t cmd [NELEM];
	logic [NELEM-1:0] cmd_credit;
	pulse_pkg::mem_wr_t mem_wr;
	logic out_valid;
	pulse_pkg::iq_t out_sample;

	// host side copy of the sample memories
	pulse_pkg::iq_t env_model [NELEM][1 << pulse_pkg::ADDR_W];
	pulse_pkg::iq_t car_model [NELEM][1 << pulse_pkg::ADDR_W];
	pulse_pkg::pulse_cmd_t cmd_list [MAX_CMD];
	int cmd_elem [MAX_CMD];
	int cmd_off [MAX_CMD];  // drive cycle within the case
	int ncmd = 0;
	pulse_pkg::iq_t exp_sum [MAX_CYC];
	logic exp_valid [MAX_CYC];
	int credits [NELEM];
	int cyc = 0;
	int limit = 40;  // reset margin before any case budget
	int base = 0;
	logic case_on = 1'b0;
	logic [31:0] rng = 32'h4340613e;

	pulse_gen_top #(
		.NELEM(NELEM),
		.CMD_DEPTH(CMD_DEPTH)
	) UUT (
		.elem(elem),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.mem_wr(mem_wr),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

	always #4 elem = ~elem;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	`include "pulse_gen_checks.svh"

	always @(posedge elem) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			abort_run("simulation ran past its cycle limit");
		end
	end

	// credit counting and output compare on the falling edge
	always @(negedge elem) begin : monitor
		int rel;
		if (rst_n) begin
			for (int e = 0; e < NELEM; e++) begin
				if (cmd_credit[e]) begin
					if (credits[e] >= CMD_DEPTH) begin
						abort_run("credit returned with no command outstanding");
					end
					credits[e]++;
				end
			end
			if (case_on) begin
				rel = cyc - base;
				check_valid(out_valid, exp_valid[rel]);
				if (out_valid) begin
					check_sample(out_sample, exp_sum[rel]);
				end
			end else if (out_valid) begin
				abort_run("out_valid high outside a running case");
			end
		end
	end

	initial begin
		int fd;
		int code;
		int ncases;
		string line;
		logic [31:0] f [8];
		rst_n = 1'b0;
		cmd_valid = '0;
		mem_wr = '0;
		ncases = 0;
		for (int e = 0; e < NELEM; e++) begin
			cmd[e] = '0;
			credits[e] = CMD_DEPTH;
		end
		repeat (3) @(posedge elem);
		rst_n <= 1'b1;
		fd = $fopen("verif/pulse_cases.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the case file verif/pulse_cases.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.getc(0) == "#") begin
				continue;
			end
			if (line.getc(0) == "w") begin
				code = $sscanf(line, "w %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (code != 8) begin
					abort_run("malformed memory line in the case file");
				end
				load_mem(f[0], f[1], f[2], f[3], f[4][15:0], f[5][15:0], f[6][15:0],
					f[7][15:0]);
			end else if (line.getc(0) == "c") begin
				code = $sscanf(line, "c %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (code != 8) begin
					abort_run("malformed command line in the case file");
				end
				cmd_elem[ncmd] = f[0];
				cmd_off[ncmd] = f[1];
				cmd_list[ncmd].env_start = pulse_pkg::ADDR_W'(f[2]);
				cmd_list[ncmd].env_len = pulse_pkg::ADDR_W'(f[3]);
				cmd_list[ncmd].car_start = pulse_pkg::ADDR_W'(f[4]);
				cmd_list[ncmd].amp.i = f[6][15:0];
				cmd_list[ncmd].amp.q = f[7][15:0];
				if (f[5][0]) begin  // random amplitude
					rng = lcg_next(rng);
					cmd_list[ncmd].amp.i = rng[31:16];
					rng = lcg_next(rng);
					cmd_list[ncmd].amp.q = rng[31:16];
				end
				ncmd++;
			end else if (line.getc(0) == "e") begin
				code = $sscanf(line, "e %h", f[0]);
				run_case(f[0]);
				ncmd = 0;
				ncases++;
			end
		end
		$fclose(fd);
		if (ncases == 0) begin
			abort_run("the case file held no cases");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- rtl/pulse_gen_top.sv
// multi-element pulse generator
`timescale 1ns/1ps

module pulse_gen_top #(
	parameter int NELEM = 4,
	parameter int CMD_DEPTH = 2
) (
	input  logic                  elem,
	input  logic                  rst_n,
	input  logic [NELEM-1:0]      cmd_valid,
	input  pulse_pkg::pulse_cmd_t cmd [NELEM],
	output logic [NELEM-1:0]      cmd_credit,
	input  pulse_pkg::mem_wr_t    mem_wr,
	output logic                  out_valid,
	output pulse_pkg::iq_t        out_sample
);

	logic [NELEM-1:0] elem_valid;
	pulse_pkg::iq_t elem_sample [NELEM];

	for (genvar e = 0; e < NELEM; e++) begin : g_elem
		pulse_element #(
			.ELEM_ID(e),
			.CMD_DEPTH(CMD_DEPTH)
		) u_elem (
			.elem(elem),
			.rst_n(rst_n),
			.cmd_valid(cmd_valid[e]),
			.cmd(cmd[e]),
			.cmd_credit(cmd_credit[e]),
			.mem_wr(mem_wr),  // broadcast, decoded per element
			.out_valid(elem_valid[e]),
			.out_sample(elem_sample[e])
		);
	end

	element_sum #(
		.NELEM(NELEM)
	) u_sum (
		.elem(elem),
		.rst_n(rst_n),
		.in_valid(elem_valid),
		.in_sample(elem_sample),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

endmodule

//--- rtl/element_sum.sv
// element stream adder tree
`timescale 1ns/1ps

module element_sum #(
	parameter int NELEM = 4
) (
	input  logic             elem,
	input  logic             rst_n,
	input  logic [NELEM-1:0] in_valid,
	input  pulse_pkg::iq_t   in_sample [NELEM],
	output logic             out_valid,
	output pulse_pkg::iq_t   out_sample
);

	localparam int LVL = $clog2(NELEM);

	pulse_pkg::iq_t leaf [NELEM];     // idle elements count as zero
	pulse_pkg::iq_t node [1:NELEM-1]; // node k sums children 2k and 2k+1
	logic [LVL:0] vld_sr;

	for (genvar e = 0; e < NELEM; e++) begin : g_leaf
		assign leaf[e] = in_valid[e] ? in_sample[e] : '0;
	end

	for (genvar k = 1; k < NELEM; k++) begin : g_node
		pulse_pkg::iq_t a;
		pulse_pkg::iq_t b;
		if (2 * k >= NELEM) begin : g_from_leaf
			assign a = leaf[2*k-NELEM];
			assign b = leaf[2*k+1-NELEM];
		end else begin : g_from_node
			assign a = node[2*k];
			assign b = node[2*k+1];
		end
		always_ff @(posedge elem) begin
			node[k].i <= a.i + b.i;  // wraps at 16 bits, no overflow check
			node[k].q <= a.q + b.q;
		end
	end

	always_ff @(posedge elem) begin
		out_sample <= node[1];
	end

	// valid follows the tree depth plus the output register
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[LVL-1:0], |in_valid};
		end
	end

	assign out_valid = vld_sr[LVL];

endmodule

//--- rtl/pulse_element.sv
// single pulse element
`timescale 1ns/1ps

module pulse_element #(
	parameter int ELEM_ID = 0,
	parameter int CMD_DEPTH = 2
) (
	input  logic                  elem,
	input  logic                  rst_n,
	input  logic                  cmd_valid,
	input  pulse_pkg::pulse_cmd_t cmd,
	output logic                  cmd_credit,
	input  pulse_pkg::mem_wr_t    mem_wr,
	output logic                  out_valid,
	output pulse_pkg::iq_t        out_sample
);

	localparam int DEPTH = 1 << pulse_pkg::ADDR_W;

	logic hit;
	logic env_we;
	logic car_we;
	logic [pulse_pkg::ADDR_W-1:0] env_addr;
	logic [pulse_pkg::ADDR_W-1:0] car_addr;
	logic rd_valid;
	logic rd_valid_d;  // aligned with memory read data
	pulse_pkg::iq_t amp;
	pulse_pkg::iq_t amp_d;
	pulse_pkg::iq_t env_data;
	pulse_pkg::iq_t car_data;

	assign hit = mem_wr.en && (mem_wr.elem == 8'(ELEM_ID));
	assign env_we = hit && (mem_wr.sel == pulse_pkg::SEL_ENV);
	assign car_we = hit && (mem_wr.sel == pulse_pkg::SEL_CAR);

	pulse_sequencer #(
		.CMD_DEPTH(CMD_DEPTH)
	) u_seq (
		.elem(elem),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.env_addr(env_addr),
		.car_addr(car_addr),
		.rd_valid(rd_valid),
		.amp(amp)
	);

	sample_mem #(.DEPTH(DEPTH)) env_mem (
		.elem(elem),
		.we(env_we),
		.waddr(mem_wr.addr),
		.wdata(mem_wr.data),
		.raddr(env_addr),
		.rdata(env_data)
	);

	sample_mem #(.DEPTH(DEPTH)) car_mem (
		.elem(elem),
		.we(car_we),
		.waddr(mem_wr.addr),
		.wdata(mem_wr.data),
		.raddr(car_addr),
		.rdata(car_data)
	);

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid_d <= 1'b0;
		end else begin
			rd_valid_d <= rd_valid;
		end
	end

	always_ff @(posedge elem) begin
		amp_d <= amp;
	end

	iq_modulator u_mod (
		.elem(elem),
		.rst_n(rst_n),
		.in_valid(rd_valid_d),
		.env(env_data),
		.car(car_data),
		.amp(amp_d),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

	// memories are loaded only between pulses of this element
	a_wr_idle: assert property (@(posedge elem) disable iff (!rst_n)
		hit |-> !rd_valid);

endmodule

//--- rtl/iq_modulator.sv
// complex envelope carrier amplitude modulator
`timescale 1ns/1ps

module iq_modulator (
	input  logic           elem,
	input  logic           rst_n,
	input  logic           in_valid,
	input  pulse_pkg::iq_t env,
	input  pulse_pkg::iq_t car,
	input  pulse_pkg::iq_t amp,
	output logic           out_valid,
	output pulse_pkg::iq_t out_sample
);

	localparam int W = pulse_pkg::SAMPLE_W;
	localparam int LAT = pulse_pkg::MOD_LAT;

	logic signed [2*W:0] s1_i;  // env x car at full width
	logic signed [2*W:0] s1_q;
	pulse_pkg::iq_t s2_p;
	logic signed [2*W:0] s3_i;  // p x amp at full width
	logic signed [2*W:0] s3_q;
	pulse_pkg::iq_t amp_d1;
	pulse_pkg::iq_t amp_d2;
	logic [LAT-1:0] vld_sr;

	always_ff @(posedge elem) begin
		// stage 1
		s1_i <= env.i * car.i - env.q * car.q;
		s1_q <= env.i * car.q + env.q * car.i;
		amp_d1 <= amp;
		// stage 2 shifts right by 15 and keeps the low word
		s2_p.i <= s1_i[W+14:15];
		s2_p.q <= s1_q[W+14:15];
		amp_d2 <= amp_d1;
		// stage 3
		s3_i <= s2_p.i * amp_d2.i - s2_p.q * amp_d2.q;
		s3_q <= s2_p.i * amp_d2.q + s2_p.q * amp_d2.i;
		// stage 4
		out_sample.i <= s3_i[W+14:15];
		out_sample.q <= s3_q[W+14:15];
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[LAT-2:0], in_valid};
		end
	end

	assign out_valid = vld_sr[LAT-1];

endmodule

//--- rtl/pulse_sequencer.sv
// pulse command sequencer
`timescale 1ns/1ps

module pulse_sequencer #(
	parameter int CMD_DEPTH = 2
) (
	input  logic                         elem,
	input  logic                         rst_n,
	input  logic                         cmd_valid,
	input  pulse_pkg::pulse_cmd_t        cmd,
	output logic                         cmd_credit,
	output logic [pulse_pkg::ADDR_W-1:0] env_addr,
	output logic [pulse_pkg::ADDR_W-1:0] car_addr,
	output logic                         rd_valid,
	output pulse_pkg::iq_t               amp
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	pulse_pkg::pulse_cmd_t queue [CMD_DEPTH];
	pulse_pkg::pulse_cmd_t head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic busy;
	logic [pulse_pkg::ADDR_W-1:0] left;  // addresses still to issue
	logic last;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head = queue[rd_ptr];
	assign last = busy && (left == pulse_pkg::ADDR_W'(1));
	// next command starts as the running one issues its last address
	assign pop = (count != '0) && (!busy || last);
	assign cmd_credit = pop;  // credit back on removal from the queue
	assign rd_valid = busy;

	always_ff @(posedge elem) begin
		if (cmd_valid) begin
			queue[wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			busy <= 1'b0;
			left <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
			if (pop) begin
				busy <= (head.env_len != '0);  // zero length pulse is only credited
				left <= head.env_len;
			end else if (busy) begin
				busy <= !last;
				left <= left - 1'b1;
			end
		end
	end

	// address counters and the amplitude held for the running pulse
	always_ff @(posedge elem) begin
		if (pop) begin
			env_addr <= head.env_start;
			car_addr <= head.car_start;
			amp <= head.amp;
		end else if (busy) begin
			env_addr <= env_addr + 1'b1;
			car_addr <= car_addr + 1'b1;
		end
	end

	// host sent a command without a credit
	a_no_push_full: assert property (@(posedge elem) disable iff (!rst_n)
		cmd_valid |-> (count != CNT_W'(CMD_DEPTH)));

endmodule

//--- rtl/sample_mem.sv
// envelope and carrier sample memory
`timescale 1ns/1ps

module sample_mem #(
	parameter int DEPTH = 1 << pulse_pkg::ADDR_W
) (
	input  logic                         elem,
	input  logic                         we,
	input  logic [pulse_pkg::ADDR_W-1:0] waddr,
	input  pulse_pkg::iq_t               wdata,
	input  logic [pulse_pkg::ADDR_W-1:0] raddr,
	output pulse_pkg::iq_t               rdata
);

	pulse_pkg::iq_t mem [DEPTH];

	// one write port, read data registered
	always_ff @(posedge elem) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

//--- rtl/pulse_pkg.sv
// pulse generator shared types
package pulse_pkg;

	localparam int SAMPLE_W = 16;  // one signed I or Q part
	localparam int ADDR_W = 10;    // sample memory address width

	// fixed depth of the I/Q modulator pipeline
	localparam int MOD_LAT = 4;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] i;
		logic signed [SAMPLE_W-1:0] q;
	} iq_t;

	typedef struct packed {
		logic [ADDR_W-1:0] env_start;
		logic [ADDR_W-1:0] env_len;  // zero means no samples
		logic [ADDR_W-1:0] car_start;
		iq_t amp;
	} pulse_cmd_t;

	typedef enum logic {
		SEL_ENV = 1'b0,
		SEL_CAR = 1'b1
	} mem_sel_t;

	// broadcast to all elements, each keeps the writes for its own index
	typedef struct packed {
		logic en;
		logic [7:0] elem;
		mem_sel_t sel;
		logic [ADDR_W-1:0] addr;
		iq_t data;
	} mem_wr_t;

endpackage
